// ==== include/vic_clock_macros.svh ====
`ifndef VIC_CLOCK_MACROS_SVH
`define VIC_CLOCK_MACROS_SVH

// phase accumulator width shared by both oscillators
`define ACC_WIDTH 24

// increments are f_target / f_sys * 2**24 with sys_clock at 100 MHz
// every value stays below 2**23, so an enable can never repeat on back-to-back cycles

// pal dot 4x, 31.527954 MHz
`define DOT_INC_PAL 24'd5289513

// ntsc dot 4x, 32.727272 MHz
`define DOT_INC_NTSC 24'd5490725

// pal color 4x, 17.734475 MHz (4 x 4.43361875 MHz subcarrier)
`define COL_INC_PAL 24'd2975351

// ntsc color 4x, 14.318181 MHz (4 x 3.579545 MHz subcarrier)
`define COL_INC_NTSC 24'd2402192

// enables counted before an oscillator reports lock
`define LOCK_PULSES 64

// power-up hold, about 40 ms at 100 MHz
// must fit in HOLD_WIDTH bits
`define HOLD_CYCLES 4000000

// width of the hold counter in the reset sequencer
`define HOLD_WIDTH 22

`endif

// ==== verilog/vic_clock_pkg.sv ====
package vic_clock_pkg;

    // chip variants as seen by the rest of the video core
    // encoding matches the chip select used across the design
    typedef enum logic [1:0] {
        // ntsc, 65 cycles per line
        CHIP6567R8   = 2'd0,
        // old ntsc revision, reserved, never produced here
        CHIP6567R56A = 2'd1,
        // pal-b
        CHIP6569     = 2'd2,
        // pal-n, reserved
        CHIP6572     = 2'd3
    } chip_t;

    // quarter-phase index, 0 to 3
    // dot side: sub-phase inside one pixel
    // color side: chroma quadrature step (0, 90, 180, 270 degrees)
    typedef logic [1:0] phase_t;

endpackage : vic_clock_pkg

// ==== verilog/dot_clock_gen.sv ====
`include "vic_clock_macros.svh"

module dot_clock_gen (
    input  logic                  sys_clock,
    input  logic                  internal_rst,
    input  vic_clock_pkg::chip_t  chip,
    output logic                  dot4x_en,
    output vic_clock_pkg::phase_t dot_phase,
    output logic                  dot_locked
);
    import vic_clock_pkg::*;

    // pulse counter sized to hold LOCK_PULSES itself
    localparam int cnt_width = $clog2(`LOCK_PULSES + 1);
    localparam logic [cnt_width-1:0] lock_last = cnt_width'(`LOCK_PULSES - 1);
    localparam logic [cnt_width-1:0] lock_full = cnt_width'(`LOCK_PULSES);

    logic [`ACC_WIDTH-1:0] dot_inc;
    logic [`ACC_WIDTH-1:0] acc;
    logic [`ACC_WIDTH-1:0] acc_sum;
    logic                  carry;
    logic [cnt_width-1:0]  pulse_cnt;

    // increment follows the latched chip type
    // reserved codes fall back to ntsc timing
    always_comb begin
        if (chip == CHIP6569) begin
            dot_inc = `DOT_INC_PAL;
        end else begin
            dot_inc = `DOT_INC_NTSC;
        end
    end

    // carry out of the accumulator marks one 4x dot period
    assign {carry, acc_sum} = {1'b0, acc} + {1'b0, dot_inc};

    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            acc        <= '0;
            dot4x_en   <= 1'b0;
            dot_phase  <= '0;
            pulse_cnt  <= '0;
            dot_locked <= 1'b0;
        end else begin
            acc      <= acc_sum;
            // enable is the registered carry, one sys_clock wide
            dot4x_en <= carry;
            if (carry) begin
                // sub-phase moves together with the enable it belongs to
                dot_phase <= dot_phase + 2'd1;
                // saturate once lock is reached
                if (pulse_cnt != lock_full) begin
                    pulse_cnt <= pulse_cnt + 1'b1;
                end
                // lock shows up with the LOCK_PULSES-th enable
                if (pulse_cnt == lock_last) begin
                    dot_locked <= 1'b1;
                end
            end
        end
    end

    // increment below half range, so no two enables in a row
    a_dot_en_single: assert property (
        @(posedge sys_clock) disable iff (internal_rst)
        dot4x_en |=> !dot4x_en
    ) else $error("dot4x_en high on consecutive cycles");

    // lock is sticky until the next reset
    a_dot_lock_sticky: assert property (
        @(posedge sys_clock) disable iff (internal_rst)
        dot_locked |=> dot_locked
    ) else $error("dot_locked fell outside reset");

endmodule : dot_clock_gen

// ==== verilog/color_clock_gen.sv ====
`include "vic_clock_macros.svh"

module color_clock_gen (
    input  logic                  sys_clock,
    input  logic                  internal_rst,
    input  vic_clock_pkg::chip_t  chip,
    output logic                  col4x_en,
    output vic_clock_pkg::phase_t col_phase,
    output logic                  col_locked
);
    import vic_clock_pkg::*;

    // enough bits to count up to LOCK_PULSES
    localparam int cnt_width = $clog2(`LOCK_PULSES + 1);
    localparam logic [cnt_width-1:0] lock_last = cnt_width'(`LOCK_PULSES - 1);
    localparam logic [cnt_width-1:0] lock_full = cnt_width'(`LOCK_PULSES);

    logic [`ACC_WIDTH-1:0] col_inc;
    logic [`ACC_WIDTH-1:0] acc;
    logic [`ACC_WIDTH-1:0] acc_sum;
    logic                  carry;
    logic [cnt_width-1:0]  pulse_cnt;

    // pal subcarrier vs ntsc subcarrier
    // anything not pal runs at the ntsc rate
    always_comb begin
        if (chip == CHIP6569) begin
            col_inc = `COL_INC_PAL;
        end else begin
            col_inc = `COL_INC_NTSC;
        end
    end

    // accumulator wrap gives one quarter of a subcarrier cycle
    assign {carry, acc_sum} = {1'b0, acc} + {1'b0, col_inc};

    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            acc        <= '0;
            col4x_en   <= 1'b0;
            col_phase  <= '0;
            pulse_cnt  <= '0;
            col_locked <= 1'b0;
        end else begin
            acc      <= acc_sum;
            col4x_en <= carry;
            if (carry) begin
                // quadrature index for the chroma modulator
                // steps 0, 90, 180, 270 degrees
                col_phase <= col_phase + 2'd1;
                if (pulse_cnt != lock_full) begin
                    pulse_cnt <= pulse_cnt + 1'b1;
                end
                // lock rises in the same cycle as the last counted enable
                if (pulse_cnt == lock_last) begin
                    col_locked <= 1'b1;
                end
            end
        end
    end

    // color enable is a single-cycle pulse
    a_col_en_single: assert property (
        @(posedge sys_clock) disable iff (internal_rst)
        col4x_en |=> !col4x_en
    ) else $error("col4x_en high on consecutive cycles");

    // quadrature only steps with its enable
    // first cycle out of reset is skipped, the clear lands there
    a_col_phase_step: assert property (
        @(posedge sys_clock) disable iff (internal_rst)
        (!$stable(col_phase) && !$past(internal_rst)) |-> col4x_en
    ) else $error("col_phase changed without col4x_en");

endmodule : color_clock_gen

// ==== verilog/reset_sequencer.sv ====
`include "vic_clock_macros.svh"

module reset_sequencer #(
    parameter int unsigned hold_cycles = `HOLD_CYCLES
) (
    input  logic                 sys_clock,
    input  logic                 internal_rst,
    input  logic                 is_pal,
    input  logic                 dot_locked,
    input  logic                 col_locked,
    output vic_clock_pkg::chip_t chip,
    output logic                 locked,
    output logic                 rst
);
    import vic_clock_pkg::*;

    localparam int hold_w = `HOLD_WIDTH;
    // hold target in counter width
    localparam logic [hold_w-1:0] hold_limit = hold_w'(hold_cycles);

    logic [hold_w-1:0] hold_cnt;
    logic              hold_done;
    logic              running;
    logic              rst_stage1;

    // strap is only looked at while internal_rst is high
    // chip is then fixed for the whole run
    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            chip <= is_pal ? CHIP6569 : CHIP6567R8;
        end
    end

    // power-up hold, counts once per cycle and parks at the limit
    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            hold_cnt <= '0;
        end else if (!hold_done) begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    assign hold_done = (hold_cnt == hold_limit);

    // both oscillators have to be locked
    // inputs are sticky, so locked never drops outside reset
    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            locked <= 1'b0;
        end else begin
            locked <= dot_locked & col_locked;
        end
    end

    // hold time done and clocks stable
    assign running = locked & hold_done;

    // two flops between running and the video reset
    // rst drops two cycles after running first goes high
    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            rst_stage1 <= 1'b1;
            rst        <= 1'b1;
        end else begin
            rst_stage1 <= ~running;
            rst        <= rst_stage1;
        end
    end

    // video core stays in reset while the clocks were unlocked recently
    a_rst_until_locked: assert property (
        @(posedge sys_clock) disable iff (internal_rst)
        (!$past(locked) || !$past(locked, 2)) |-> rst
    ) else $error("rst released less than two cycles after lock");

    // chip select must not move once the core is out of reset
    a_chip_stable: assert property (
        @(posedge sys_clock) disable iff (internal_rst)
        !$past(internal_rst) |-> $stable(chip)
    ) else $error("chip changed outside reset");

endmodule : reset_sequencer

// ==== verilog/clockgen_top.sv ====
`include "vic_clock_macros.svh"

module clockgen_top #(
    parameter int unsigned hold_cycles = `HOLD_CYCLES
) (
    input  logic                  sys_clock,
    input  logic                  internal_rst,
    input  logic                  is_pal,
    output logic                  dot4x_en,
    output logic                  col4x_en,
    output vic_clock_pkg::phase_t dot_phase,
    output vic_clock_pkg::phase_t col_phase,
    output logic                  locked,
    output logic                  rst,
    output vic_clock_pkg::chip_t  chip
);

    // per-oscillator lock levels into the sequencer
    logic dot_locked;
    logic col_locked;

    // 4x dot rate enable and pixel sub-phase
    dot_clock_gen u_dot (
        .sys_clock    (sys_clock),
        .internal_rst (internal_rst),
        .chip         (chip),
        .dot4x_en     (dot4x_en),
        .dot_phase    (dot_phase),
        .dot_locked   (dot_locked)
    );

    // 4x color rate enable and chroma quadrature
    color_clock_gen u_col (
        .sys_clock    (sys_clock),
        .internal_rst (internal_rst),
        .chip         (chip),
        .col4x_en     (col4x_en),
        .col_phase    (col_phase),
        .col_locked   (col_locked)
    );

    // chip latch, hold timer and video reset release
    reset_sequencer #(
        .hold_cycles (hold_cycles)
    ) u_seq (
        .sys_clock    (sys_clock),
        .internal_rst (internal_rst),
        .is_pal       (is_pal),
        .dot_locked   (dot_locked),
        .col_locked   (col_locked),
        .chip         (chip),
        .locked       (locked),
        .rst          (rst)
    );

endmodule : clockgen_top

// ==== sim/clockgen_tb.sv ====
`include "vic_clock_macros.svh"

module clockgen_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import vic_clock_pkg::*;

    // short hold so both phases reach the release
    localparam int unsigned hold_len = 200;
    localparam int pal_cycles = 3000;
    localparam int ntsc_cycles = 3000;
    localparam int rst_cycles = 5;
    // twice both run phases plus the reset windows
    localparam int cycle_limit = 2 * (pal_cycles + ntsc_cycles) + 2 * rst_cycles;
    localparam int num_tests = 6;
    localparam int t_chip = 0;
    localparam int t_dot = 1;
    localparam int t_col = 2;
    localparam int t_lock = 3;
    localparam int t_rel = 4;
    localparam int t_rere = 5;

    logic   sys_clock;
    logic   internal_rst;
    logic   is_pal;
    logic   dot4x_en;
    logic   col4x_en;
    phase_t dot_phase;
    phase_t col_phase;
    logic   locked;
    logic   rst;
    chip_t  chip;

    // reference model state aligned cycle for cycle with the DUT outputs
    chip_t             m_chip;
    longint unsigned   m_k;
    longint unsigned   m_dot_cnt;
    longint unsigned   m_col_cnt;
    logic              m_dot_en;
    logic              m_col_en;
    logic              m_dot_lock;
    logic              m_col_lock;
    logic              m_locked;
    logic              m_stage1;
    logic              m_rst;
    longint unsigned   dot_inc;
    longint unsigned   col_inc;
    longint unsigned   dot_next;
    longint unsigned   dot_prev;
    longint unsigned   col_next;
    longint unsigned   col_prev;
    logic              run_now;

    // pulses seen on the DUT ports up to the previous cycle
    longint unsigned   obs_dot_cnt;
    longint unsigned   obs_col_cnt;
    logic              saw_locked;
    logic              saw_release;

    int    err_cnt [num_tests];
    int    err_base [num_tests];
    string test_names [num_tests] = '{"chip_select", "dot_rate", "color_rate_and_phase",
                                      "lock_detect", "reset_release", "re_reset"};
    string phase_name;
    int    pass_cnt;
    int    fail_cnt;
    int    cycle_cnt = 0;

    clockgen_top #(
        .hold_cycles (hold_len)
    ) u_dut (
        .sys_clock    (sys_clock),
        .internal_rst (internal_rst),
        .is_pal       (is_pal),
        .dot4x_en     (dot4x_en),
        .col4x_en     (col4x_en),
        .dot_phase    (dot_phase),
        .col_phase    (col_phase),
        .locked       (locked),
        .rst          (rst),
        .chip         (chip)
    );

    // 40 ns period
    initial begin
        sys_clock = 1'b0;
        forever #20 sys_clock = ~sys_clock;
    end

    // increments and pulse counts straight from the floor rule
    always_comb begin
        dot_inc  = (m_chip == CHIP6569) ? `DOT_INC_PAL : `DOT_INC_NTSC;
        col_inc  = (m_chip == CHIP6569) ? `COL_INC_PAL : `COL_INC_NTSC;
        dot_next = ((m_k + 1) * dot_inc) >> `ACC_WIDTH;
        dot_prev = (m_k * dot_inc) >> `ACC_WIDTH;
        col_next = ((m_k + 1) * col_inc) >> `ACC_WIDTH;
        col_prev = (m_k * col_inc) >> `ACC_WIDTH;
        // running as seen in the cycle that is ending
        run_now  = m_locked && (m_k >= hold_len);
    end

    always @(posedge sys_clock) begin
        if (internal_rst) begin
            // strap picks the chip while reset is held
            m_chip     <= is_pal ? CHIP6569 : CHIP6567R8;
            m_k        <= 0;
            m_dot_cnt  <= 0;
            m_col_cnt  <= 0;
            m_dot_en   <= 1'b0;
            m_col_en   <= 1'b0;
            m_dot_lock <= 1'b0;
            m_col_lock <= 1'b0;
            m_locked   <= 1'b0;
            m_stage1   <= 1'b1;
            m_rst      <= 1'b1;
        end else begin
            m_k        <= m_k + 1;
            m_dot_cnt  <= dot_next;
            m_col_cnt  <= col_next;
            m_dot_en   <= dot_next > dot_prev;
            m_col_en   <= col_next > col_prev;
            // lock comes with the 64th enable
            m_dot_lock <= dot_next >= `LOCK_PULSES;
            m_col_lock <= col_next >= `LOCK_PULSES;
            m_locked   <= m_dot_lock && m_col_lock;
            m_stage1   <= !run_now;
            m_rst      <= m_stage1;
        end
    end

    // pulse counters and reach flags on the DUT side
    always @(posedge sys_clock) begin
        if (internal_rst) begin
            obs_dot_cnt <= 0;
            obs_col_cnt <= 0;
            saw_locked  <= 1'b0;
            saw_release <= 1'b0;
        end else begin
            obs_dot_cnt <= obs_dot_cnt + dot4x_en;
            obs_col_cnt <= obs_col_cnt + col4x_en;
            if (locked) saw_locked <= 1'b1;
            if (!rst) saw_release <= 1'b1;
        end
    end

    a_chip: assert property (@(posedge sys_clock) disable iff (internal_rst)
        chip == m_chip
    ) else begin
        err_cnt[t_chip] += 1;
        $display("[ERROR] %s chip_select expected %0d actual %0d",
                 phase_name, $sampled(m_chip), $sampled(chip));
    end

    a_dot_en: assert property (@(posedge sys_clock) disable iff (internal_rst)
        dot4x_en == m_dot_en
    ) else begin
        err_cnt[t_dot] += 1;
        $display("[ERROR] %s dot_rate enable at k=%0d expected %0b actual %0b",
                 phase_name, $sampled(m_k), $sampled(m_dot_en), $sampled(dot4x_en));
    end

    // count through this cycle including the current enable
    a_dot_cnt: assert property (@(posedge sys_clock) disable iff (internal_rst)
        obs_dot_cnt + dot4x_en == m_dot_cnt
    ) else begin
        err_cnt[t_dot] += 1;
        $display("[ERROR] %s dot_rate count at k=%0d expected %0d actual %0d", phase_name,
                 $sampled(m_k), $sampled(m_dot_cnt), $sampled(obs_dot_cnt) + $sampled(dot4x_en));
    end

    a_col_en: assert property (@(posedge sys_clock) disable iff (internal_rst)
        col4x_en == m_col_en && obs_col_cnt + col4x_en == m_col_cnt
    ) else begin
        err_cnt[t_col] += 1;
        $display("[ERROR] %s color_rate_and_phase count at k=%0d expected %0d actual %0d",
                 phase_name, $sampled(m_k), $sampled(m_col_cnt),
                 $sampled(obs_col_cnt) + $sampled(col4x_en));
    end

    // both phases are the pulse count modulo 4
    a_phases: assert property (@(posedge sys_clock) disable iff (internal_rst)
        dot_phase == m_dot_cnt[1:0] && col_phase == m_col_cnt[1:0]
    ) else begin
        err_cnt[t_col] += 1;
        $display("[ERROR] %s color_rate_and_phase phases expected %0d/%0d actual %0d/%0d",
                 phase_name, $sampled(m_dot_cnt) % 4, $sampled(m_col_cnt) % 4,
                 $sampled(dot_phase), $sampled(col_phase));
    end

    a_lock: assert property (@(posedge sys_clock) disable iff (internal_rst)
        locked == m_locked
    ) else begin
        err_cnt[t_lock] += 1;
        $display("[ERROR] %s lock_detect at k=%0d expected %0b actual %0b",
                 phase_name, $sampled(m_k), $sampled(m_locked), $sampled(locked));
    end

    a_lock_sticky: assert property (@(posedge sys_clock) disable iff (internal_rst)
        locked |=> locked
    ) else begin
        err_cnt[t_lock] += 1;
        $display("[ERROR] %s lock_detect locked fell before reset", phase_name);
    end

    a_release: assert property (@(posedge sys_clock) disable iff (internal_rst)
        rst == m_rst
    ) else begin
        err_cnt[t_rel] += 1;
        $display("[ERROR] %s reset_release at k=%0d expected %0b actual %0b",
                 phase_name, $sampled(m_k), $sampled(m_rst), $sampled(rst));
    end

    // one reset edge is enough to clear everything
    a_re_reset: assert property (@(posedge sys_clock)
        internal_rst |=> (!dot4x_en && !col4x_en && !locked && rst)
    ) else begin
        err_cnt[t_rere] += 1;
        $display({"[ERROR] %s re_reset expected en 0/0 locked 0 rst 1",
                  " actual en %0b/%0b locked %0b rst %0b"},
                 phase_name, $sampled(dot4x_en), $sampled(col4x_en),
                 $sampled(locked), $sampled(rst));
    end

    // hard stop in case the stimulus stalls
    always @(posedge sys_clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout, the run hung after %0d cycles", cycle_cnt);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic apply_reset(input logic pal);
        @(posedge sys_clock);
        #2;
        internal_rst = 1'b1;
        is_pal = pal;
        repeat (rst_cycles) @(posedge sys_clock);
        #2;
        internal_rst = 1'b0;
    endtask

    // random strap level in windows of random length
    task automatic run_with_toggles(input int n);
        int left;
        int win;
        left = n;
        while (left > 0) begin
            win = 1 + ($urandom % 64);
            if (win > left) win = left;
            repeat (win) @(posedge sys_clock);
            #2;
            is_pal = ($urandom % 2) != 0;
            left -= win;
        end
    endtask

    task automatic report_test(input int idx, input bit reached);
        int errs;
        errs = err_cnt[idx] - err_base[idx];
        if (!reached) begin
            $display("%s %s: FAIL, stimulus never reached the checked condition",
                     phase_name, test_names[idx]);
            fail_cnt++;
        end else if (errs != 0) begin
            $display("%s %s: FAIL, %0d mismatches", phase_name, test_names[idx], errs);
            fail_cnt++;
        end else begin
            $display("%s %s: ok", phase_name, test_names[idx]);
            pass_cnt++;
        end
    endtask

    // re_reset keeps its count from power-up until its own report
    task automatic report_phase();
        report_test(t_chip, 1'b1);
        report_test(t_dot, 1'b1);
        report_test(t_col, 1'b1);
        report_test(t_lock, saw_locked);
        report_test(t_rel, saw_release);
        for (int i = 0; i <= t_rel; i++) begin
            err_base[i] = err_cnt[i];
        end
    endtask

    initial begin
        int seed_val;
        internal_rst = 1'b1;
        is_pal = 1'b1;
        pass_cnt = 0;
        fail_cnt = 0;
        for (int i = 0; i < num_tests; i++) begin
            err_cnt[i] = 0;
            err_base[i] = 0;
        end
        seed_val = $urandom(67);

        // pal run with the strap held steady
        phase_name = "pal";
        apply_reset(1'b1);
        repeat (pal_cycles) @(posedge sys_clock);
        #2;
        report_phase();

        // ntsc run after a re-reset while the strap wanders outside reset
        phase_name = "ntsc";
        apply_reset(1'b0);
        @(posedge sys_clock);
        #2;
        report_test(t_rere, 1'b1);
        run_with_toggles(ntsc_cycles - 1);
        report_phase();

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : clockgen_tb

// ==== all.f ====
+incdir+include
verilog/vic_clock_pkg.sv
verilog/dot_clock_gen.sv
verilog/color_clock_gen.sv
verilog/reset_sequencer.sv
verilog/clockgen_top.sv
sim/clockgen_tb.sv
